// ==== Bender.yml ====
package:
  name: aes_enc

sources:
  - src/aes_pkg.sv
  - src/aes_ctrl_pkg.sv
  - src/aes_block_if.sv
  - src/aes_block_loader.sv
  - src/aes_add_round_key.sv
  - src/aes_round_engine.sv
  - src/aes_enc_top.sv
  - target: test
    files:
      - tb/aes_enc_assert.sv
      - tb/aes_enc_tb.sv

// ==== src.f ====
src/aes_pkg.sv
src/aes_ctrl_pkg.sv
src/aes_block_if.sv
src/aes_block_loader.sv
src/aes_add_round_key.sv
src/aes_round_engine.sv
src/aes_enc_top.sv
tb/aes_enc_assert.sv
tb/aes_enc_tb.sv

// ==== src/aes_add_round_key.sv ====
`timescale 1ns/10ps

module aes_add_round_key (
    input  logic            clk,
    input  logic            resetn,
    input  logic            reg_empty,       // Result register may be written
    input  logic            rd_comp,         // Round key ready pulse
    input  aes_pkg::block_t p,
    input  aes_pkg::block_t k,
    output aes_pkg::block_t o,
    output logic            ok               // Low for one cycle with a result
);

    logic            empty_q;
    logic            comp_q;
    aes_pkg::block_t p_q;
    aes_pkg::block_t k_q;

    // Operands captured with the key strobe
    always_ff @(posedge clk)
    begin
        if (rd_comp)
        begin
            p_q <= p;
            k_q <= k;
        end
    end

    always_ff @(posedge clk or negedge resetn)
    begin
        if (!resetn)
        begin
            empty_q <= 1'b0;
            comp_q  <= 1'b0;
            o       <= '0;
            ok      <= 1'b1;
        end
        else
        begin
            empty_q <= reg_empty;
            comp_q  <= rd_comp;
            if (empty_q && comp_q)           // Both strobes seen last cycle
            begin
                for (int i = 0; i < 16; i++)
                    o[i] <= p_q[i] ^ k_q[i];
                ok <= 1'b0;
            end
            else
                ok <= 1'b1;
        end
    end

endmodule

// ==== src/aes_block_if.sv ====
`timescale 1ns/10ps

// Loader to engine link
interface aes_block_if;

    aes_pkg::block_t block;                  // Assembled plaintext
    aes_pkg::block_t key;                    // Cipher key
    logic            req;                    // One-cycle start request
    logic            busy;                   // Engine has a block in flight

    modport loader
    (
        output block,
        output key,
        output req,
        input  busy
    );

    modport engine
    (
        input  block,
        input  key,
        input  req,
        output busy
    );

endinterface

// ==== src/aes_block_loader.sv ====
`timescale 1ns/10ps

module aes_block_loader #(
    parameter int WORD_W = 32                // 32, 64 or 128
) (
    input  logic              clk,
    input  logic              resetn,
    input  logic              wr,
    input  logic [2:0]        wr_addr,
    input  logic [WORD_W-1:0] wr_data,
    input  logic              start,
    aes_block_if.loader       bus
);

    localparam int WPB = 128 / WORD_W;       // Words per block

    aes_ctrl_pkg::wr_op_e op;
    logic [1:0]           idx;               // Word slot within block
    logic [127:0]         plain_q;
    logic [127:0]         key_q;

    always_comb
    begin
        idx = wr_addr[1:0];
        if (!wr)
            op = aes_ctrl_pkg::op_none;
        else if (wr_addr[2])
            op = aes_ctrl_pkg::op_key;       // Addresses 4 to 7
        else
            op = aes_ctrl_pkg::op_plain;     // Addresses 0 to 3
    end

    // Word 0 lands in the low bits
    always_ff @(posedge clk)
    begin
        if (idx < WPB)                       // Slots past the block are dropped
        begin
            case (op)
                aes_ctrl_pkg::op_plain: plain_q[idx*WORD_W +: WORD_W] <= wr_data;
                aes_ctrl_pkg::op_key:   key_q[idx*WORD_W +: WORD_W]   <= wr_data;
                default:                ;
            endcase
        end
    end

    // Start only passes while the engine is free
    always_ff @(posedge clk or negedge resetn)
    begin
        if (!resetn)
            bus.req <= 1'b0;
        else
            bus.req <= start && !bus.busy;
    end

    assign bus.block = plain_q;
    assign bus.key   = key_q;

endmodule

// ==== src/aes_ctrl_pkg.sv ====
package aes_ctrl_pkg;

    // Host write decode
    typedef enum logic [1:0]
    {
        op_none,                             // No write this cycle
        op_plain,                            // Plaintext word
        op_key                               // Key word
    } wr_op_e;

    // Round engine sequencing
    typedef enum logic [1:0]
    {
        st_idle,                             // Waiting for req
        st_prep,                             // Form state and key, pulse rd_comp
        st_wait                              // AddRoundKey in flight
    } eng_state_e;

endpackage

// ==== src/aes_enc_top.sv ====
`timescale 1ns/10ps

module aes_enc_top #(
    parameter int WORD_W = 32                // Host bus width
) (
    input  logic              clk,
    input  logic              resetn,
    input  logic              wr,
    input  logic [2:0]        wr_addr,       // 0 to 3 plaintext, 4 to 7 key
    input  logic [WORD_W-1:0] wr_data,
    input  logic              start,
    output logic              busy,
    output aes_pkg::block_t   ct,
    output logic              ok             // Low for one cycle per block
);

    aes_block_if blk_bus ();

    aes_block_loader #(
        .WORD_W (WORD_W)
    ) u_loader (
        .clk     (clk),
        .resetn  (resetn),
        .wr      (wr),
        .wr_addr (wr_addr),
        .wr_data (wr_data),
        .start   (start),
        .bus     (blk_bus.loader)
    );

    aes_round_engine u_engine (
        .clk    (clk),
        .resetn (resetn),
        .bus    (blk_bus.engine),
        .ct     (ct),
        .done_n (ok)
    );

    assign busy = blk_bus.busy;              // Engine level straight out

endmodule

// ==== src/aes_pkg.sv ====
package aes_pkg;

    localparam int NR = 10;                  // Rounds for a 128-bit key

    typedef logic [15:0][7:0] block_t;       // Byte 0 in bits 7:0, column-major state
    typedef logic [3:0][7:0]  word_t;        // One 32-bit column or key word

    // Multiply by x modulo the AES polynomial
    function automatic logic [7:0] xtime(input logic [7:0] a);
        return {a[6:0], 1'b0} ^ (a[7] ? 8'h1b : 8'h00);
    endfunction

    function automatic logic [7:0] gf_mul(input logic [7:0] a, input logic [7:0] b);
        logic [7:0] acc;
        logic [7:0] sh;
        acc = '0;
        sh  = a;
        for (int i = 0; i < 8; i++)
        begin
            if (b[i])
                acc ^= sh;                   // Add shifted partial product
            sh = xtime(sh);
        end
        return acc;
    endfunction

    // Inverse as a^254, zero maps to zero
    function automatic logic [7:0] gf_inv(input logic [7:0] a);
        logic [7:0] sq;
        logic [7:0] acc;
        sq  = a;
        acc = 8'h01;
        for (int i = 1; i < 8; i++)
        begin
            sq  = gf_mul(sq, sq);            // a^(2^i)
            acc = gf_mul(acc, sq);
        end
        return acc;
    endfunction

    function automatic logic [7:0] sbox(input logic [7:0] a);
        logic [7:0] x;
        x = gf_inv(a);
        return x ^ {x[6:0], x[7]} ^ {x[5:0], x[7:6]}     // Affine map
                 ^ {x[4:0], x[7:5]} ^ {x[3:0], x[7:4]} ^ 8'h63;
    endfunction

    // Round constant for rounds 1 to NR
    function automatic logic [7:0] rcon(input logic [3:0] rnd);
        logic [7:0] c;
        c = 8'h01;
        for (int i = 1; i < NR; i++)
        begin
            if (i < rnd)
                c = xtime(c);                // Doubling per round
        end
        return c;
    endfunction

endpackage

// ==== src/aes_round_engine.sv ====
`timescale 1ns/10ps

module aes_round_engine (
    input  logic            clk,
    input  logic            resetn,
    aes_block_if.engine     bus,
    output aes_pkg::block_t ct,
    output logic            done_n           // Active-low result strobe
);

    aes_ctrl_pkg::eng_state_e state_q;
    logic [3:0]               rnd_q;         // 0 is the initial key addition
    aes_pkg::block_t          st_q;          // Cipher state between rounds
    aes_pkg::block_t          rk_q;          // Last used round key
    aes_pkg::block_t          ct_q;
    aes_pkg::block_t          sb;            // After SubBytes
    aes_pkg::block_t          sr;            // After ShiftRows
    aes_pkg::block_t          mc;            // After MixColumns
    aes_pkg::block_t          nk;            // Next round key
    aes_pkg::block_t          p;
    aes_pkg::block_t          k;
    aes_pkg::word_t           tmp;           // RotWord, SubWord, Rcon
    aes_pkg::block_t          ark_o;
    logic                     ark_ok;
    logic                     last;
    logic                     res_last;

    assign last     = (rnd_q == 4'(aes_pkg::NR));
    assign res_last = last && (state_q == aes_ctrl_pkg::st_wait) && !ark_ok;

    always_comb
    begin
        for (int i = 0; i < 16; i++)
            sb[i] = aes_pkg::sbox(st_q[i]);
        for (int c = 0; c < 4; c++)
            for (int r = 0; r < 4; r++)
                sr[4*c+r] = sb[4*((c+r)%4)+r];       // Row r rotates left by r
        for (int c = 0; c < 4; c++)
        begin
            mc[4*c]   = aes_pkg::xtime(sr[4*c] ^ sr[4*c+1]) ^ sr[4*c+1]
                      ^ sr[4*c+2] ^ sr[4*c+3];
            mc[4*c+1] = aes_pkg::xtime(sr[4*c+1] ^ sr[4*c+2]) ^ sr[4*c+2]
                      ^ sr[4*c+3] ^ sr[4*c];
            mc[4*c+2] = aes_pkg::xtime(sr[4*c+2] ^ sr[4*c+3]) ^ sr[4*c+3]
                      ^ sr[4*c] ^ sr[4*c+1];
            mc[4*c+3] = aes_pkg::xtime(sr[4*c+3] ^ sr[4*c]) ^ sr[4*c]
                      ^ sr[4*c+1] ^ sr[4*c+2];
        end
        if (rnd_q == 4'd0)
            p = st_q;                        // Plaintext straight in
        else if (last)
            p = sr;                          // No MixColumns in the final round
        else
            p = mc;
    end

    // Key schedule, one step per round
    always_comb
    begin
        tmp[0] = aes_pkg::sbox(rk_q[13]) ^ aes_pkg::rcon(rnd_q);
        tmp[1] = aes_pkg::sbox(rk_q[14]);
        tmp[2] = aes_pkg::sbox(rk_q[15]);
        tmp[3] = aes_pkg::sbox(rk_q[12]);
        for (int j = 0; j < 4; j++)
            nk[j] = rk_q[j] ^ tmp[j];
        for (int i = 4; i < 16; i++)
            nk[i] = rk_q[i] ^ nk[i-4];       // Chain through the words
        k = (rnd_q == 4'd0) ? rk_q : nk;
    end

    always_ff @(posedge clk or negedge resetn)
    begin
        if (!resetn)
        begin
            state_q <= aes_ctrl_pkg::st_idle;
            rnd_q   <= 4'd0;
            ct_q    <= '0;
        end
        else
        begin
            case (state_q)
                aes_ctrl_pkg::st_idle:
                    if (bus.req)
                    begin
                        state_q <= aes_ctrl_pkg::st_prep;
                        rnd_q   <= 4'd0;
                    end
                aes_ctrl_pkg::st_prep:
                    state_q <= aes_ctrl_pkg::st_wait;
                default:
                    if (!ark_ok)             // Result of this round is out
                    begin
                        if (last)
                            state_q <= aes_ctrl_pkg::st_idle;
                        else
                        begin
                            state_q <= aes_ctrl_pkg::st_prep;
                            rnd_q   <= rnd_q + 4'd1;
                        end
                    end
            endcase
            if (res_last)
                ct_q <= ark_o;
        end
    end

    // Block and key copied on req so later writes do not reach this block
    always_ff @(posedge clk)
    begin
        if (state_q == aes_ctrl_pkg::st_idle && bus.req)
        begin
            st_q <= bus.block;
            rk_q <= bus.key;
        end
        else if (state_q == aes_ctrl_pkg::st_prep)
            rk_q <= k;
        else if (state_q == aes_ctrl_pkg::st_wait && !ark_ok)
            st_q <= ark_o;
    end

    aes_add_round_key u_ark (
        .clk       (clk),
        .resetn    (resetn),
        .reg_empty (state_q != aes_ctrl_pkg::st_wait),
        .rd_comp   (state_q == aes_ctrl_pkg::st_prep),
        .p         (p),
        .k         (k),
        .o         (ark_o),
        .ok        (ark_ok)
    );

    assign bus.busy = bus.req || (state_q != aes_ctrl_pkg::st_idle);
    assign ct       = res_last ? ark_o : ct_q;   // Valid in the ok cycle and held after
    assign done_n   = ark_ok || !last;

endmodule

// ==== tb/aes_enc_assert.sv ====
`timescale 1ns/10ps

module aes_enc_assert (
    input logic clk,
    input logic resetn,
    input logic start,
    input logic busy,
    input logic ok
);

    int fail_count;                                      // Assertion failures so far

    // Result strobe lasts a single cycle
    ok_one_cycle: assert property (@(posedge clk) disable iff (!resetn)
        !ok |=> ok)
        else
        begin
            $error("ok held low for more than one cycle");
            fail_count++;
        end

    // Idle outputs right after reset release
    idle_after_reset: assert property (@(posedge clk)
        $rose(resetn) |-> (!busy && ok))
        else
        begin
            $error("busy or ok wrong after reset");
            fail_count++;
        end

    // Accepted start gives the result 34 cycles later and not before
    start_to_ok: assert property (@(posedge clk) disable iff (!resetn)
        (start && !busy) |-> ##1 ok [*33] ##1 !ok)
        else
        begin
            $error("ok not 34 cycles after start");
            fail_count++;
        end

endmodule

bind aes_enc_top aes_enc_assert u_assert (
    .clk    (clk),
    .resetn (resetn),
    .start  (start),
    .busy   (busy),
    .ok     (ok)
);

// ==== tb/aes_enc_tb.sv ====
`timescale 1ns/10ps

module aes_enc_tb;

    localparam int MAX_CYCLES = 16 + 30 * 60;            // 30 blocks at 60 cycles each
    localparam logic [127:0] FIPS_PT = 128'hffeeddccbbaa99887766554433221100;
    localparam logic [127:0] FIPS_KEY = 128'h0f0e0d0c0b0a09080706050403020100;
    localparam logic [127:0] FIPS_CT = 128'h5ac5b47080b7cdd830047b6ad8e0c469;

    logic         clk;
    logic         resetn;
    logic         wr;
    logic [2:0]   wr_addr;
    logic [31:0]  wr_data;
    logic         start;
    logic         busy;
    logic [127:0] ct;                                    // Byte 0 in bits 7:0
    logic         ok;

    logic [7:0]   sbox_tab [256];
    logic [127:0] exp_q [$];                             // Expected ciphertexts in order
    logic [127:0] cur_pt;                                // Words last written
    logic [127:0] cur_key;
    int           cycles;
    int           errors;
    int           checks;
    int           tests;
    int           err_mark;
    int           assert_mark;                           // Bound assertion failures already counted
    int           issued;
    int           done_count;

    aes_enc_top #(
        .WORD_W (32)
    ) dut0 (
        .clk     (clk),
        .resetn  (resetn),
        .wr      (wr),
        .wr_addr (wr_addr),
        .wr_data (wr_data),
        .start   (start),
        .busy    (busy),
        .ct      (ct),
        .ok      (ok)
    );

    initial
    begin
        clk = 1'b0;
        forever
            #2 clk = ~clk;                               // 4 ns period
    end

    function automatic logic [7:0] gmul(input logic [7:0] a, input logic [7:0] b);
        logic [7:0] acc;
        logic [7:0] aa;
        acc = 8'h00;
        aa  = a;
        for (int i = 0; i < 8; i++)
        begin
            if (b[i])
                acc ^= aa;
            aa = {aa[6:0], 1'b0} ^ (aa[7] ? 8'h1b : 8'h00);
        end
        return acc;
    endfunction

    // Inverse found by search, then the affine map bit by bit
    task automatic build_sbox;
        logic [7:0] inv;
        logic [7:0] x;
        for (int a = 0; a < 256; a++)
        begin
            inv = 8'h00;
            for (int b = 1; b < 256; b++)
                if (gmul(8'(a), 8'(b)) == 8'h01)
                    inv = 8'(b);
            for (int i = 0; i < 8; i++)
                x[i] = inv[i] ^ inv[(i+4)%8] ^ inv[(i+5)%8] ^ inv[(i+6)%8] ^ inv[(i+7)%8];
            sbox_tab[a] = x ^ 8'h63;
        end
    endtask

    function automatic logic [127:0] aes_ref(input logic [127:0] pt, input logic [127:0] key);
        logic [7:0]   s [16];
        logic [7:0]   t [16];
        logic [7:0]   w [16];
        logic [7:0]   g [4];
        logic [7:0]   rc;
        logic [127:0] res;
        rc = 8'h01;
        for (int i = 0; i < 16; i++)
        begin
            w[i] = key[8*i +: 8];
            s[i] = pt[8*i +: 8] ^ w[i];                  // Initial key addition
        end
        for (int r = 1; r <= 10; r++)
        begin
            g[0] = sbox_tab[w[13]] ^ rc;                 // RotWord, SubWord, Rcon
            g[1] = sbox_tab[w[14]];
            g[2] = sbox_tab[w[15]];
            g[3] = sbox_tab[w[12]];
            for (int i = 0; i < 4; i++)
                w[i] = w[i] ^ g[i];
            for (int i = 4; i < 16; i++)
                w[i] = w[i] ^ w[i-4];
            rc = gmul(rc, 8'h02);
            for (int c = 0; c < 4; c++)
                for (int rr = 0; rr < 4; rr++)
                    t[4*c+rr] = sbox_tab[s[4*((c+rr)%4)+rr]];
            for (int c = 0; c < 4; c++)
                for (int rr = 0; rr < 4; rr++)
                    if (r < 10)
                        s[4*c+rr] = gmul(t[4*c+rr], 8'h02) ^ gmul(t[4*c+(rr+1)%4], 8'h03)
                                  ^ t[4*c+(rr+2)%4] ^ t[4*c+(rr+3)%4] ^ w[4*c+rr];
                    else
                        s[4*c+rr] = t[4*c+rr] ^ w[4*c+rr];   // Last round skips MixColumns
        end
        for (int i = 0; i < 16; i++)
            res[8*i +: 8] = s[i];
        return res;
    endfunction

    task automatic check(input string name, input logic [127:0] got, input logic [127:0] exp);
        checks++;
        if (got !== exp)
        begin
            errors++;
            $display("Fail at %0t ns: %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic load(input logic is_key, input logic [127:0] v);
        for (int i = 0; i < 4; i++)
        begin
            @(posedge clk);
            #1;
            wr      = 1'b1;
            wr_addr = {is_key, 2'(i)};                   // Word 0 first
            wr_data = v[32*i +: 32];
        end
        @(posedge clk);
        #1;
        wr = 1'b0;
        if (is_key)
            cur_key = v;
        else
            cur_pt = v;
    endtask

    task automatic pulse_start;
        @(posedge clk);
        #1;
        start = 1'b1;
        @(posedge clk);
        #1;
        start = 1'b0;
    endtask

    task automatic start_block(input logic [127:0] exp);
        exp_q.push_back(exp);
        issued++;
        pulse_start();
    endtask

    task automatic wait_done;
        wait (done_count == issued);
        repeat (2) @(posedge clk);
    endtask

    task automatic end_test(input string name);
        errors += dut0.u_assert.fail_count - assert_mark;   // Fold in strobe timing failures
        assert_mark = dut0.u_assert.fail_count;
        tests++;
        if (errors == err_mark)
            $display("test %0d %s: passed", tests, name);
        else
            $display("test %0d %s: failed with %0d errors", tests, name, errors - err_mark);
        err_mark = errors;
    endtask

    function automatic logic [127:0] rand_block();
        return {$urandom(), $urandom(), $urandom(), $urandom()};
    endfunction

    // Compare process with one check per ok pulse
    always @(posedge clk)
    begin
        if (resetn && ok === 1'b0)
        begin
            done_count++;
            if (exp_q.size() == 0)
            begin
                errors++;
                $display("Error at %0t ns: ok pulse with no block pending", $time);
            end
            else
                check("ct", ct, exp_q.pop_front());
        end
    end

    always @(posedge clk)
    begin
        cycles++;
        if (cycles == MAX_CYCLES)
        begin
            $display("Timeout after %0d cycles, result never arrived", cycles);
            $display("Simulation finished: FAIL");
            $finish;
        end
    end

    initial
    begin
        int base;
        wr      = 1'b0;
        wr_addr = 3'd0;
        wr_data = 32'd0;
        start   = 1'b0;
        resetn  = 1'b0;
        void'($urandom(32'hc4f49c44));
        build_sbox();
        repeat (16) @(posedge clk);
        #1;
        resetn = 1'b1;
        @(posedge clk);
        check("ok", ok, 1'b1);                           // Idle state before any start
        check("busy", busy, 1'b0);
        check("ct", ct, '0);
        end_test("reset values");

        check("reference", aes_ref(FIPS_PT, FIPS_KEY), FIPS_CT);
        load(1'b0, FIPS_PT);
        load(1'b1, FIPS_KEY);
        start_block(FIPS_CT);
        wait_done();
        end_test("FIPS-197 C.1 vector");

        for (int n = 0; n < 20; n++)
        begin
            load(1'b0, rand_block());
            load(1'b1, rand_block());
            start_block(aes_ref(cur_pt, cur_key));
            wait_done();
            end_test("random block");
        end

        base = done_count;
        load(1'b0, rand_block());
        start_block(aes_ref(cur_pt, cur_key));
        repeat (5) @(posedge clk);
        pulse_start();                                   // Dropped while busy
        wait_done();
        repeat (45) @(posedge clk);
        check("ok pulses", done_count - base, 1);
        end_test("start during busy");

        start_block(aes_ref(cur_pt, cur_key));
        load(1'b0, rand_block());                        // Lands mid block
        load(1'b1, rand_block());
        wait_done();
        start_block(aes_ref(cur_pt, cur_key));
        wait_done();
        end_test("writes during busy");

        load(1'b1, rand_block());
        start_block(aes_ref(cur_pt, cur_key));
        wait_done();
        load(1'b0, rand_block());
        start_block(aes_ref(cur_pt, cur_key));
        wait_done();
        end_test("partial rewrite");

        $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
        if (errors == 0)
            $display("Simulation finished: PASS");
        else
            $display("Simulation finished: FAIL");
        $finish;
    end

endmodule
